// ==== Makefile ====
# Verilator build and run for the glue logic testbench

VERILATOR ?= verilator
TOP       ?= glue_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+rtl
rtl/glue_pkg.sv
rtl/reset_sequencer.sv
rtl/video_sync_monitor.sv
rtl/system_status.sv
rtl/glue_top.sv
tb/glue_sva.sv
tb/glue_tb.sv

// ==== rtl/glue_cfg.svh ====
/*
 * build-time sizes for the board glue logic
 * included by the package, the RTL blocks and the testbench
 */
`ifndef GLUE_CFG_SVH
`define GLUE_CFG_SVH

//----------------------------------------------------------------------
// reset sequencing
//----------------------------------------------------------------------
`define GLUE_RST_FRAMES 3   // sof pulses held after last source drops

//----------------------------------------------------------------------
// power led dimming
//----------------------------------------------------------------------
`define GLUE_LED_CNT_W 4    // dim low 1 of 2**W counts

// m68k interrupt priority lines, active low
`define GLUE_IPL_W 3

`endif

// ==== rtl/glue_pkg.sv ====
/*
 * shared types for the board glue logic
 * config fields from the user-I/O side and the reset source bundle
 */
`include "glue_cfg.svh"

package glue_pkg;

	//------------------------------------------------------------------
	// plain vector types
	//------------------------------------------------------------------
	// [1:0] chip ram size, 3 = 2MB
	typedef logic [6:0] mem_cfg_t;

	// [1] ntsc request, [4] aga
	typedef logic [4:0] chipset_cfg_t;

	// [2] fast chip, [3] fast kick
	typedef logic [3:0] cpu_cfg_t;

	// m68k ipl, active low
	typedef logic [`GLUE_IPL_W-1:0] ipl_t;

	//------------------------------------------------------------------
	// bundles
	//------------------------------------------------------------------
	// 16 bits from the user-I/O block
	typedef struct packed {
		mem_cfg_t     mem;      // memory layout
		chipset_cfg_t chipset;  // chipset features
		cpu_cfg_t     cpu;      // cpu speed options
	} sys_cfg_t;

	// reset requests, all active high
	typedef struct packed {
		logic kbd;      // ctrl-amiga-amiga from keyboard
		logic usr;      // user reset from osd
		logic ext;      // external ctrl block
		logic kbd_key;  // keyboard reset line, already inverted
	} rst_src_t;

endpackage

// ==== rtl/glue_top.sv ====
/*
 * board glue top level: reset sequencing, sync monitoring and status
 * instances only, no logic of its own
 */
module glue_top (
	input  logic               clk,
	input  logic               reset,          // power-on reset
	input  logic               clk7_en_i,      // 7MHz enable
	input  logic               sof_i,          // start of frame from agnus
	input  logic               vsync_n_i,
	input  logic               hsync_n_i,
	input  logic               cpu_rst_n_i,    // reset seen at the cpu
	input  logic               cpu_rst_req_i,  // cpu reset request
	input  logic               led_n_i,        // cia power led
	input  logic               ovl_i,          // kickstart overlay
	input  logic               cpu_custom_i,
	input  logic               int7_i,         // level 7 from cartridge
	input  glue_pkg::rst_src_t src_i,
	input  glue_pkg::sys_cfg_t cfg_i,
	input  glue_pkg::ipl_t     ipl_i,
	output logic               rst_o,          // overall reset status
	output logic               cpu_reset_n_o,
	output logic               frame_tgl_o,    // vsync for the mcu
	output glue_pkg::mem_cfg_t memcfg_o,
	output glue_pkg::cpu_cfg_t cpu_cfg_o,
	output logic               ntsc_o,
	output logic               turbo_chip_o,
	output logic               turbo_kick_o,
	output logic               pwr_led_o,
	output logic               filter_o,
	output glue_pkg::ipl_t     cpu_ipl_o
);

	logic sys_reset;  // stretched system reset
	logic led_dim;    // led duty level

	//------------------------------------------------------------------
	// parallel front blocks
	//------------------------------------------------------------------
	reset_sequencer i_reset_sequencer (
		.clk           (clk),
		.reset         (reset),
		.clk7_en_i     (clk7_en_i),
		.src_i         (src_i),
		.sof_i         (sof_i),
		.cpu_rst_n_i   (cpu_rst_n_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.sys_reset_o   (sys_reset),
		.rst_o         (rst_o),
		.cpu_reset_n_o (cpu_reset_n_o)
	);

	video_sync_monitor i_video_sync_monitor (
		.clk         (clk),
		.reset       (reset),
		.clk7_en_i   (clk7_en_i),
		.vsync_n_i   (vsync_n_i),
		.hsync_n_i   (hsync_n_i),
		.frame_tgl_o (frame_tgl_o),
		.led_dim_o   (led_dim)
	);

	// status combines both, latch gated by the sequenced reset
	system_status i_system_status (
		.clk          (clk),
		.clk7_en_i    (clk7_en_i),
		.rst_i        (rst_o),
		.led_dim_i    (led_dim),
		.led_n_i      (led_n_i),
		.ovl_i        (ovl_i),
		.cpu_custom_i (cpu_custom_i),
		.int7_i       (int7_i),
		.cfg_i        (cfg_i),
		.ipl_i        (ipl_i),
		.memcfg_o     (memcfg_o),
		.cpu_cfg_o    (cpu_cfg_o),
		.ntsc_o       (ntsc_o),
		.turbo_chip_o (turbo_chip_o),
		.turbo_kick_o (turbo_kick_o),
		.pwr_led_o    (pwr_led_o),
		.filter_o     (filter_o),
		.cpu_ipl_o    (cpu_ipl_o)
	);

endmodule

// ==== rtl/reset_sequencer.sv ====
/*
 * merges the reset sources and stretches system reset over a few frames
 * also derives overall reset status and the cpu reset line
 */
`include "glue_cfg.svh"

module reset_sequencer (
	input  logic               clk,
	input  logic               reset,          // power-on reset
	input  logic               clk7_en_i,      // 7MHz enable
	input  glue_pkg::rst_src_t src_i,          // other reset sources
	input  logic               sof_i,          // start of frame
	input  logic               cpu_rst_n_i,    // reset seen at the cpu
	input  logic               cpu_rst_req_i,  // cpu reset request
	output logic               sys_reset_o,
	output logic               rst_o,
	output logic               cpu_reset_n_o
);

	//------------------------------------------------------------------
	// frame counter sizing
	//------------------------------------------------------------------
	localparam int CNT_W = $clog2(`GLUE_RST_FRAMES + 1);
	localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(`GLUE_RST_FRAMES - 1);

	logic             hold;         // some source still active
	logic             frame_tick;   // sof qualified by enable
	logic [CNT_W-1:0] frame_cnt;    // frames since last release
	logic             sys_reset_q;

	// por is just another source here
	assign hold = reset
		| src_i.kbd
		| src_i.usr
		| src_i.ext
		| src_i.kbd_key;

	assign frame_tick = clk7_en_i & sof_i;  // sof only counts in enable cycles

	//------------------------------------------------------------------
	// hold and count
	//------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (hold) begin
			frame_cnt   <= '0;     // restart on every new request
			sys_reset_q <= 1'b1;
		end else if (sys_reset_q && frame_tick) begin
			if (frame_cnt == LAST_FRAME) begin
				sys_reset_q <= 1'b0;  // last frame seen, let go
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	//------------------------------------------------------------------
	// derived resets
	//------------------------------------------------------------------
	assign sys_reset_o = sys_reset_q;

	// cpu may still be holding its own reset after we release
	assign rst_o = sys_reset_q | ~cpu_rst_n_i;

	// cpu held by us or by its own reset request
	assign cpu_reset_n_o = ~(sys_reset_q | cpu_rst_req_i);

endmodule

// ==== rtl/system_status.sv ====
/*
 * registers the user-I/O config, latches pal/ntsc during reset,
 * derives turbo enables and drives led, filter and cpu ipl lines
 */
module system_status (
	input  logic               clk,
	input  logic               clk7_en_i,     // 7MHz enable
	input  logic               rst_i,         // sequenced reset status
	input  logic               led_dim_i,     // dim level from sync monitor
	input  logic               led_n_i,       // cia power led, active low
	input  logic               ovl_i,         // kickstart overlay
	input  logic               cpu_custom_i,  // agnus lets cpu on the bus
	input  logic               int7_i,        // level 7 request
	input  glue_pkg::sys_cfg_t cfg_i,         // config from user-I/O
	input  glue_pkg::ipl_t     ipl_i,         // ipl from paula
	output glue_pkg::mem_cfg_t memcfg_o,
	output glue_pkg::cpu_cfg_t cpu_cfg_o,
	output logic               ntsc_o,
	output logic               turbo_chip_o,
	output logic               turbo_kick_o,
	output logic               pwr_led_o,
	output logic               filter_o,
	output glue_pkg::ipl_t     cpu_ipl_o
);

	import glue_pkg::*;

	//------------------------------------------------------------------
	// config field positions
	//------------------------------------------------------------------
	localparam int CS_NTSC_BIT    = 1;  // chipset, ntsc request
	localparam int CS_AGA_BIT     = 4;  // chipset, aga mode
	localparam int CPU_FCHIP_BIT  = 2;  // cpu, fast chip
	localparam int CPU_FKICK_BIT  = 3;  // cpu, fast kick
	localparam logic [1:0] CHIP_2MB = 2'b11;

	sys_cfg_t cfg_q;   // registered copy of cfg_i
	logic     aga;
	logic     chip_2mb;
	logic     ntsc_q;

	//------------------------------------------------------------------
	// config register
	//------------------------------------------------------------------
	always_ff @(posedge clk) begin
		cfg_q <= cfg_i;  // one cycle behind the user-I/O block
	end

	assign memcfg_o  = cfg_q.mem;
	assign cpu_cfg_o = cfg_q.cpu;

	//------------------------------------------------------------------
	// pal/ntsc
	//------------------------------------------------------------------
	// mode only follows the osd while in reset, so a switch needs a reset
	always_ff @(posedge clk) begin
		if (rst_i && clk7_en_i) begin
			ntsc_q <= cfg_q.chipset[CS_NTSC_BIT];
		end
	end

	assign ntsc_o = ntsc_q;

	//------------------------------------------------------------------
	// turbo enables
	//------------------------------------------------------------------
	assign aga      = cfg_q.chipset[CS_AGA_BIT];
	assign chip_2mb = (cfg_q.mem[1:0] == CHIP_2MB);

	// aga, no overlay, fast chip on, bus free and 2MB chip ram
	assign turbo_chip_o = aga & ~ovl_i & cfg_q.cpu[CPU_FCHIP_BIT]
		& cpu_custom_i & chip_2mb;

	// aga, no overlay and fast kick on
	assign turbo_kick_o = aga & ~ovl_i & cfg_q.cpu[CPU_FKICK_BIT];

	//------------------------------------------------------------------
	// led, filter, interrupts
	//------------------------------------------------------------------
	assign pwr_led_o = ~(led_n_i & led_dim_i);  // glows dimly when "off"
	assign filter_o  = ~led_n_i;                // audio filter follows the led

	// nmi overrides paula
	assign cpu_ipl_o = int7_i ? '0 : ipl_i;

endmodule

// ==== rtl/video_sync_monitor.sv ====
/*
 * watches the sync levels: frame toggle for the host mcu on falling vsync
 * and a low duty dim level for the power led while hsync is high
 */
`include "glue_cfg.svh"

module video_sync_monitor (
	input  logic clk,
	input  logic reset,
	input  logic clk7_en_i,    // 7MHz enable
	input  logic vsync_n_i,    // vertical sync, active low
	input  logic hsync_n_i,    // horizontal sync, active low
	output logic frame_tgl_o,  // flips once per frame
	output logic led_dim_o     // low one count in 2**W
);

	logic                       vsync_del;   // vsync one enable ago
	logic                       vsync_fall;
	logic [`GLUE_LED_CNT_W-1:0] led_cnt;

	//------------------------------------------------------------------
	// frame toggle for the mcu
	//------------------------------------------------------------------
	// falling edge as seen between two enable cycles
	assign vsync_fall = ~vsync_n_i & vsync_del;

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_del   <= 1'b0;   // no edge right out of reset
			frame_tgl_o <= 1'b0;
		end else if (clk7_en_i) begin
			vsync_del <= vsync_n_i;
			if (vsync_fall) begin
				frame_tgl_o <= ~frame_tgl_o;  // osd update sync
			end
		end
	end

	//------------------------------------------------------------------
	// power led dimming
	//------------------------------------------------------------------
	// counter free runs during the hsync high level
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt   <= '0;
			led_dim_o <= 1'b0;
		end else if (hsync_n_i) begin
			led_cnt   <= led_cnt + 1'b1;
			led_dim_o <= |led_cnt;  // old value, so zero count gives the low slot
		end
	end

endmodule

// ==== tb/glue_sva.sv ====
/*
 * concurrent checks on the glue top level, attached with bind
 * covers reset requests, reset release on a counted frame and the pal/ntsc latch
 */
module glue_sva (
	input  logic               clk,
	input  logic               reset,
	input  logic               clk7_en_i,
	input  logic               sof_i,
	input  glue_pkg::rst_src_t src_i,
	input  logic               sys_reset_i,    // stretched reset inside the top
	input  logic               rst_i,
	input  logic               cpu_reset_n_i,
	input  logic               ntsc_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// any request puts status and cpu in reset from the next clock
	src_holds_reset: assert property (@(posedge clk) disable iff (reset)
		(src_i != '0) |=> (sys_reset_i && rst_i && !cpu_reset_n_i))
		else $error("reset source seen but system reset not raised");

	// release only on a start of frame counted in an enable cycle
	release_on_sof: assert property (@(posedge clk) disable iff (reset)
		$fell(sys_reset_i) |-> $past(clk7_en_i && sof_i))
		else $error("system reset released without a counted start of frame");

	// mode only moves while reset is active
	ntsc_frozen: assert property (@(posedge clk) disable iff (reset)
		!rst_i |=> $stable(ntsc_i))
		else $error("ntsc changed outside reset");

endmodule

bind glue_top glue_sva i_glue_sva (
	.clk           (clk),
	.reset         (reset),
	.clk7_en_i     (clk7_en_i),
	.sof_i         (sof_i),
	.src_i         (src_i),
	.sys_reset_i   (sys_reset),
	.rst_i         (rst_o),
	.cpu_reset_n_i (cpu_reset_n_o),
	.ntsc_i        (ntsc_o)
);

// ==== tb/glue_tb.sv ====
/*
 * directed testbench for the board glue top level
 * reset hold, reset outputs, config and turbo, mode latch, sync and led, ipl
 */
`include "glue_cfg.svh"

module glue_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import glue_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int SETTLE     = CLK_PERIOD / 4;  // outputs stable a quarter after negedge
	localparam int RST_CYCLES = 8;
	localparam int EN_PERIOD  = 4;               // clk7 enable every 4th cycle
	localparam int FRAMES     = `GLUE_RST_FRAMES;
	localparam int LED_SLOTS  = 1 << `GLUE_LED_CNT_W;
	localparam int MAX_CYCLES = 4000;            // tests need about 450 cycles

	logic clk, reset, clk7_en_i, sof_i, vsync_n_i, hsync_n_i;
	logic cpu_rst_n_i, cpu_rst_req_i, led_n_i, ovl_i, cpu_custom_i, int7_i;
	rst_src_t src_i;
	sys_cfg_t cfg_i;
	ipl_t     ipl_i;
	logic rst_o, cpu_reset_n_o, frame_tgl_o, ntsc_o, turbo_chip_o, turbo_kick_o;
	logic pwr_led_o, filter_o;
	mem_cfg_t memcfg_o;
	cpu_cfg_t cpu_cfg_o;
	ipl_t     cpu_ipl_o;

	logic [1:0]  en_cnt;
	logic [31:0] lcg_state;
	int cycle_cnt, errors, checks, tests_run;

	glue_top i_glue_top (.*);  // tb names match the ports

	always #(CLK_PERIOD / 2) clk = ~clk;

	// enable pattern driven on the falling edge like every other input
	always @(negedge clk) begin
		en_cnt    <= en_cnt + 2'd1;
		clk7_en_i <= (en_cnt == 2'd3);
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, a test never finished", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	//----------------------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------------------
	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mem(input string name, input mem_cfg_t exp, input mem_cfg_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_cpu(input string name, input cpu_cfg_t exp, input cpu_cfg_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_ipl(input string name, input ipl_t exp, input ipl_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	//----------------------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------------------
	task automatic finish_test(input string name, input int err0);
		tests_run++;
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	task automatic wait_enable();
		do @(posedge clk); while (!clk7_en_i);
	endtask

	// one cycle sof that lands on the next enabled edge
	task automatic sof_pulse();
		wait_enable();
		repeat (EN_PERIOD - 1) @(posedge clk);
		@(negedge clk);
		sof_i = 1'b1;
		@(negedge clk);
		sof_i = 1'b0;
		#(SETTLE);
	endtask

	// sof just after an enabled edge is never sampled
	task automatic stray_sof();
		wait_enable();
		@(negedge clk);
		sof_i = 1'b1;
		@(negedge clk);
		sof_i = 1'b0;
		#(SETTLE);
	endtask

	task automatic pulse_source(input rst_src_t s);
		@(negedge clk);
		src_i = s;
		@(negedge clk);
		src_i = '0;
		#(SETTLE);
	endtask

	// reset must last until the final hold frame is counted
	task automatic release_frames();
		int f;
		for (f = 0; f < FRAMES; f++) begin
			check_bit("rst_o", 1'b1, rst_o);
			sof_pulse();
		end
		check_bit("rst_o", 1'b0, rst_o);
	endtask

	//----------------------------------------------------------------------
	// tests
	//----------------------------------------------------------------------
	task automatic test_reset_state();
		int err0;
		err0 = errors;
		repeat (RST_CYCLES - 1) @(negedge clk);
		#(SETTLE);
		check_bit("rst_o", 1'b1, rst_o);
		check_bit("cpu_reset_n_o", 1'b0, cpu_reset_n_o);
		check_bit("frame_tgl_o", 1'b0, frame_tgl_o);
		check_bit("ntsc_o", 1'b0, ntsc_o);
		check_bit("pwr_led_o", 1'b1, pwr_led_o);  // dim level cleared
		@(negedge clk);
		reset = 1'b0;
		#(SETTLE);
		finish_test("reset_state", err0);
	endtask

	task automatic test_reset_hold();
		int err0;
		int i;
		err0 = errors;
		release_frames();  // power-on hold
		for (i = 0; i < 4; i++) begin
			pulse_source(rst_src_t'(4'b0001 << i));
			check_bit("cpu_reset_n_o", 1'b0, cpu_reset_n_o);
			release_frames();
		end
		// kbd first and kbd_key raised mid-count restarts it
		pulse_source(rst_src_t'(4'b1000));
		repeat (FRAMES - 1) sof_pulse();
		pulse_source(rst_src_t'(4'b0001));
		stray_sof();
		repeat (FRAMES - 1) sof_pulse();
		check_bit("rst_o", 1'b1, rst_o);
		sof_pulse();
		check_bit("rst_o", 1'b0, rst_o);
		finish_test("reset_hold", err0);
	endtask

	task automatic test_reset_outputs();
		int err0;
		int k;
		logic [1:0] kv;
		err0 = errors;
		for (k = 0; k < 4; k++) begin
			kv = 2'(k);
			@(negedge clk);
			cpu_rst_req_i = kv[0];
			cpu_rst_n_i   = kv[1];
			#(SETTLE);
			check_bit("cpu_reset_n_o", ~kv[0], cpu_reset_n_o);
			check_bit("rst_o", ~kv[1], rst_o);
		end
		@(negedge clk);
		cpu_rst_req_i = 1'b0;
		cpu_rst_n_i   = 1'b1;
		#(SETTLE);
		finish_test("reset_outputs", err0);
	endtask

	task automatic test_config_turbo();
		int err0;
		int n;
		logic [31:0] r;
		sys_cfg_t c;
		logic exp_chip;
		logic exp_kick;
		err0 = errors;
		for (n = 0; n < 24; n++) begin
			r = lcg_next();
			c = r[31:16];
			if (n % 2 == 1) begin  // steer toward the turbo corner
				c.chipset[4]  = 1'b1;
				c.cpu[3:2]    = 2'b11;
				c.mem[1:0]    = 2'b11;
			end
			@(negedge clk);
			cfg_i        = c;
			ovl_i        = r[3];
			cpu_custom_i = r[5];
			@(negedge clk);
			#(SETTLE);
			exp_chip = c.chipset[4] & ~r[3] & c.cpu[2] & r[5] & (c.mem[1:0] == 2'b11);
			exp_kick = c.chipset[4] & ~r[3] & c.cpu[3];
			check_mem("memcfg_o", c.mem, memcfg_o);
			check_cpu("cpu_cfg_o", c.cpu, cpu_cfg_o);
			check_bit("turbo_chip_o", exp_chip, turbo_chip_o);
			check_bit("turbo_kick_o", exp_kick, turbo_kick_o);
		end
		finish_test("config_turbo", err0);
	endtask

	task automatic test_mode_latch();
		int err0;
		err0 = errors;
		@(negedge clk);
		cfg_i.chipset[1] = 1'b1;
		pulse_source(rst_src_t'(4'b0100));  // usr
		wait_enable();
		@(negedge clk);
		#(SETTLE);
		check_bit("ntsc_o", 1'b1, ntsc_o);
		release_frames();
		@(negedge clk);
		cfg_i.chipset[1] = 1'b0;            // ignored without a reset
		repeat (2 * EN_PERIOD) @(negedge clk);
		#(SETTLE);
		check_bit("ntsc_o", 1'b1, ntsc_o);
		pulse_source(rst_src_t'(4'b0010));  // ext
		wait_enable();
		@(negedge clk);
		#(SETTLE);
		check_bit("ntsc_o", 1'b0, ntsc_o);
		release_frames();
		finish_test("mode_latch", err0);
	endtask

	task automatic test_sync_led();
		int err0;
		int f;
		int lit;
		logic exp_tgl;
		err0 = errors;
		exp_tgl = 1'b0;  // vsync held high since reset
		check_bit("frame_tgl_o", exp_tgl, frame_tgl_o);
		for (f = 0; f < 4; f++) begin
			@(negedge clk);
			vsync_n_i = 1'b0;
			repeat (2 * EN_PERIOD - 1) @(negedge clk);
			#(SETTLE);
			exp_tgl = ~exp_tgl;
			check_bit("frame_tgl_o", exp_tgl, frame_tgl_o);
			@(negedge clk);
			vsync_n_i = 1'b1;
			repeat (2 * EN_PERIOD - 1) @(negedge clk);
			#(SETTLE);
			check_bit("frame_tgl_o", exp_tgl, frame_tgl_o);
		end
		// led off and hsync high light one slot per counter wrap
		lit = 0;
		for (f = 0; f < 2 * LED_SLOTS; f++) begin
			@(negedge clk);
			#(SETTLE);
			if (pwr_led_o === 1'b1) lit++;
		end
		checks++;
		if (lit != 2) begin
			errors++;
			$display("pwr_led_o was high in %0d of %0d cycles, 2 expected", lit, 2 * LED_SLOTS);
		end
		check_bit("filter_o", 1'b0, filter_o);
		@(negedge clk);
		led_n_i = 1'b0;
		#(SETTLE);
		check_bit("filter_o", 1'b1, filter_o);
		check_bit("pwr_led_o", 1'b1, pwr_led_o);
		finish_test("sync_led", err0);
	endtask

	task automatic test_ipl_override();
		int err0;
		int n;
		logic [31:0] r;
		ipl_t ipl;
		err0 = errors;
		for (n = 0; n < 16; n++) begin
			r   = lcg_next();
			ipl = r[16 +: `GLUE_IPL_W];
			@(negedge clk);
			ipl_i  = ipl;
			int7_i = (n % 2 == 1);
			#(SETTLE);
			check_ipl("cpu_ipl_o", (n % 2 == 1) ? ipl_t'(0) : ipl, cpu_ipl_o);
		end
		finish_test("ipl_override", err0);
	endtask

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		clk7_en_i     = 1'b0;
		sof_i         = 1'b0;
		vsync_n_i     = 1'b1;
		hsync_n_i     = 1'b1;
		cpu_rst_n_i   = 1'b1;
		cpu_rst_req_i = 1'b0;
		led_n_i       = 1'b1;
		ovl_i         = 1'b0;
		cpu_custom_i  = 1'b0;
		int7_i        = 1'b0;
		src_i         = '0;
		cfg_i         = '0;
		ipl_i         = '1;
		en_cnt        = 2'd0;
		lcg_state     = 32'd71716;
		cycle_cnt     = 0;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		test_reset_state();
		test_reset_hold();
		test_reset_outputs();
		test_config_turbo();
		test_mode_latch();
		test_sync_led();
		test_ipl_override();
		$display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
